//--- mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Bus data width in bits
`define MEM_DATA_W 64

// Byte address width
`define MEM_ADDR_W 32

// SRAM depth in data words
`define MEM_DEPTH 256

// One strobe bit per data byte
`define MEM_STRB_W (`MEM_DATA_W / 8)

`endif

//--- axi_pkg.sv
`include "mem_defs.svh"

package axi_pkg;

    // Byte address as seen on AR and AW
    typedef logic [`MEM_ADDR_W-1:0] addr_t;

    // One bus word
    typedef logic [`MEM_DATA_W-1:0] data_t;

    // Byte enables for a write beat
    typedef logic [`MEM_STRB_W-1:0] strb_t;

    // Only the two codes this slave can return
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

endpackage

//--- arb_pkg.sv
package arb_pkg;

    // Read path owner, held from AR until the R handshake
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_IFU  = 2'd1,
        ARB_LSU  = 2'd2
    } arb_state_e;

    typedef enum logic {
        REQ_IFU = 1'b0,
        REQ_LSU = 1'b1
    } requester_e;

endpackage

//--- axi_rd_if.sv
`timescale 1ns/1ps

interface axi_rd_if
    import axi_pkg::*;
();

    // Read address channel
    logic      ar_valid;
    logic      ar_ready;
    addr_t     ar_addr;

    // Read data channel
    logic      r_valid;
    logic      r_ready;
    axi_resp_e r_resp;
    data_t     r_data;

    modport mst (
        output ar_valid,
        output ar_addr,
        input  ar_ready,
        input  r_valid,
        input  r_resp,
        input  r_data,
        output r_ready
    );

    modport slv (
        input  ar_valid,
        input  ar_addr,
        output ar_ready,
        output r_valid,
        output r_resp,
        output r_data,
        input  r_ready
    );

endinterface

//--- axi_wr_if.sv
`timescale 1ns/1ps

interface axi_wr_if
    import axi_pkg::*;
();

    // Write address channel
    logic      aw_valid;
    logic      aw_ready;
    addr_t     aw_addr;

    // Write data channel
    logic      w_valid;
    logic      w_ready;
    data_t     w_data;
    strb_t     w_strb;

    // Write response channel
    logic      b_valid;
    logic      b_ready;
    axi_resp_e b_resp;

    modport mst (
        output aw_valid,
        output aw_addr,
        input  aw_ready,
        output w_valid,
        output w_data,
        output w_strb,
        input  w_ready,
        input  b_valid,
        input  b_resp,
        output b_ready
    );

    modport slv (
        input  aw_valid,
        input  aw_addr,
        output aw_ready,
        input  w_valid,
        input  w_data,
        input  w_strb,
        output w_ready,
        output b_valid,
        output b_resp,
        input  b_ready
    );

endinterface

//--- axi_arbiter.sv
`timescale 1ns/1ps

module axi_arbiter
    import arb_pkg::*;
(
    input logic   clk,
    input logic   rst,
    axi_rd_if.slv ifu_rd,
    axi_rd_if.slv lsu_rd,
    axi_wr_if.slv lsu_wr,
    axi_rd_if.mst mem_rd,
    axi_wr_if.mst mem_wr
);

    arb_state_e state_q;
    arb_state_e state_d;
    requester_e owner;
    logic       granted;
    logic       r_done;

    assign r_done = mem_rd.r_valid && mem_rd.r_ready;

    // LSU wins a tie, grant held until the read data is taken
    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (lsu_rd.ar_valid) begin
                    state_d = ARB_LSU;
                end else if (ifu_rd.ar_valid) begin
                    state_d = ARB_IFU;
                end
            end
            ARB_IFU, ARB_LSU: begin
                if (r_done) begin
                    state_d = ARB_IDLE;
                end
            end
            default: begin
                state_d = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign granted = (state_q != ARB_IDLE);
    assign owner   = (state_q == ARB_LSU) ? REQ_LSU : REQ_IFU;

    // Read request toward the SRAM
    assign mem_rd.ar_valid = granted &&
                             ((owner == REQ_LSU) ? lsu_rd.ar_valid : ifu_rd.ar_valid);
    assign mem_rd.ar_addr  = (owner == REQ_LSU) ? lsu_rd.ar_addr : ifu_rd.ar_addr;
    assign mem_rd.r_ready  = granted &&
                             ((owner == REQ_LSU) ? lsu_rd.r_ready : ifu_rd.r_ready);

    // Loser sees no ready and no valid
    assign lsu_rd.ar_ready = granted && (owner == REQ_LSU) && mem_rd.ar_ready;
    assign ifu_rd.ar_ready = granted && (owner == REQ_IFU) && mem_rd.ar_ready;
    assign lsu_rd.r_valid  = granted && (owner == REQ_LSU) && mem_rd.r_valid;
    assign ifu_rd.r_valid  = granted && (owner == REQ_IFU) && mem_rd.r_valid;

    // Payload fans out, only valid qualifies it
    assign lsu_rd.r_data = mem_rd.r_data;
    assign lsu_rd.r_resp = mem_rd.r_resp;
    assign ifu_rd.r_data = mem_rd.r_data;
    assign ifu_rd.r_resp = mem_rd.r_resp;

    // Write side has a single master
    assign mem_wr.aw_valid = lsu_wr.aw_valid;
    assign mem_wr.aw_addr  = lsu_wr.aw_addr;
    assign mem_wr.w_valid  = lsu_wr.w_valid;
    assign mem_wr.w_data   = lsu_wr.w_data;
    assign mem_wr.w_strb   = lsu_wr.w_strb;
    assign mem_wr.b_ready  = lsu_wr.b_ready;
    assign lsu_wr.aw_ready = mem_wr.aw_ready;
    assign lsu_wr.w_ready  = mem_wr.w_ready;
    assign lsu_wr.b_valid  = mem_wr.b_valid;
    assign lsu_wr.b_resp   = mem_wr.b_resp;

    // Read data reaches only the master whose address was taken
    a_ifu_r_own: assert property (
        @(posedge clk) disable iff (rst)
        $rose(ifu_rd.r_valid) |-> $past(ifu_rd.ar_valid && ifu_rd.ar_ready)
    );

    a_lsu_r_own: assert property (
        @(posedge clk) disable iff (rst)
        $rose(lsu_rd.r_valid) |-> $past(lsu_rd.ar_valid && lsu_rd.ar_ready)
    );

    // Pending read data keeps its owner
    a_grant_hold: assert property (
        @(posedge clk) disable iff (rst)
        mem_rd.r_valid && !mem_rd.r_ready |=> granted && $stable(owner)
    );

    // Idle means no request out and no read data left behind
    a_idle_no_ar: assert property (
        @(posedge clk) disable iff (rst)
        state_q == ARB_IDLE |-> !mem_rd.ar_valid && !mem_rd.r_valid
    );

endmodule

//--- axi_sram.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module axi_sram
    import axi_pkg::*;
(
    input logic   clk,
    input logic   rst,
    axi_rd_if.slv rd,
    axi_wr_if.slv wr
);

    localparam int OFS_W = $clog2(`MEM_STRB_W);
    localparam int IDX_W = $clog2(`MEM_DEPTH);

    data_t     mem [`MEM_DEPTH];

    logic      live_q;
    logic      r_valid_q;
    axi_resp_e r_resp_q;
    data_t     r_data_q;
    logic      b_valid_q;
    axi_resp_e b_resp_q;

    logic [`MEM_ADDR_W-OFS_W-1:0] rd_word;
    logic [`MEM_ADDR_W-OFS_W-1:0] wr_word;
    logic                         rd_in_range;
    logic                         wr_in_range;
    logic                         ar_fire;
    logic                         wr_fire;

    // Word index sits above the byte offset
    assign rd_word     = rd.ar_addr[`MEM_ADDR_W-1:OFS_W];
    assign wr_word     = wr.aw_addr[`MEM_ADDR_W-1:OFS_W];
    assign rd_in_range = (rd_word < `MEM_DEPTH);
    assign wr_in_range = (wr_word < `MEM_DEPTH);

    // Keeps all readies low in the first cycle out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            live_q <= 1'b0;
        end else begin
            live_q <= 1'b1;
        end
    end

    // One read and one write in flight at most
    assign rd.ar_ready = live_q && !r_valid_q;
    assign wr.aw_ready = live_q && !b_valid_q && wr.aw_valid && wr.w_valid;
    assign wr.w_ready  = wr.aw_ready;

    assign ar_fire = rd.ar_valid && rd.ar_ready;
    assign wr_fire = wr.aw_valid && wr.aw_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid_q <= 1'b0;
            b_valid_q <= 1'b0;
        end else begin
            if (ar_fire) begin
                r_valid_q <= 1'b1;
            end else if (rd.r_ready) begin
                r_valid_q <= 1'b0;
            end
            if (wr_fire) begin
                b_valid_q <= 1'b1;
            end else if (wr.b_ready) begin
                b_valid_q <= 1'b0;
            end
        end
    end

    // Out of range reads return zero with SLVERR
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            r_data_q <= rd_in_range ? mem[rd_word[IDX_W-1:0]] : '0;
            r_resp_q <= rd_in_range ? OKAY : SLVERR;
        end
        if (wr_fire) begin
            b_resp_q <= wr_in_range ? OKAY : SLVERR;
        end
    end

    // Byte merge under the strobe, dropped when out of range
    always_ff @(posedge clk) begin
        if (wr_fire && wr_in_range) begin
            for (int i = 0; i < `MEM_STRB_W; i++) begin
                if (wr.w_strb[i]) begin
                    mem[wr_word[IDX_W-1:0]][8*i +: 8] <= wr.w_data[8*i +: 8];
                end
            end
        end
    end

    assign rd.r_valid = r_valid_q;
    assign rd.r_data  = r_data_q;
    assign rd.r_resp  = r_resp_q;
    assign wr.b_valid = b_valid_q;
    assign wr.b_resp  = b_resp_q;

    // Read data and its payload hold until taken
    a_r_after_ar: assert property (
        @(posedge clk) disable iff (rst)
        rd.r_valid && !rd.r_ready |=> rd.r_valid && $stable(rd.r_data) && $stable(rd.r_resp)
    );

endmodule

//--- mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top
    import axi_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // IFU read
    input  logic      ifu_ar_valid_i,
    input  addr_t     ifu_ar_addr_i,
    output logic      ifu_ar_ready_o,
    input  logic      ifu_r_ready_i,
    output logic      ifu_r_valid_o,
    output axi_resp_e ifu_r_resp_o,
    output data_t     ifu_r_data_o,

    // LSU read
    input  logic      lsu_ar_valid_i,
    input  addr_t     lsu_ar_addr_i,
    output logic      lsu_ar_ready_o,
    input  logic      lsu_r_ready_i,
    output logic      lsu_r_valid_o,
    output axi_resp_e lsu_r_resp_o,
    output data_t     lsu_r_data_o,

    // LSU write
    input  logic      lsu_aw_valid_i,
    input  addr_t     lsu_aw_addr_i,
    output logic      lsu_aw_ready_o,
    input  logic      lsu_w_valid_i,
    input  data_t     lsu_w_data_i,
    input  strb_t     lsu_w_strb_i,
    output logic      lsu_w_ready_o,
    input  logic      lsu_b_ready_i,
    output logic      lsu_b_valid_o,
    output axi_resp_e lsu_b_resp_o
);

    axi_rd_if ifu_rd ();
    axi_rd_if lsu_rd ();
    axi_rd_if mem_rd ();
    axi_wr_if lsu_wr ();
    axi_wr_if mem_wr ();

    assign ifu_rd.ar_valid = ifu_ar_valid_i;
    assign ifu_rd.ar_addr  = ifu_ar_addr_i;
    assign ifu_rd.r_ready  = ifu_r_ready_i;
    assign ifu_ar_ready_o  = ifu_rd.ar_ready;
    assign ifu_r_valid_o   = ifu_rd.r_valid;
    assign ifu_r_resp_o    = ifu_rd.r_resp;
    assign ifu_r_data_o    = ifu_rd.r_data;

    assign lsu_rd.ar_valid = lsu_ar_valid_i;
    assign lsu_rd.ar_addr  = lsu_ar_addr_i;
    assign lsu_rd.r_ready  = lsu_r_ready_i;
    assign lsu_ar_ready_o  = lsu_rd.ar_ready;
    assign lsu_r_valid_o   = lsu_rd.r_valid;
    assign lsu_r_resp_o    = lsu_rd.r_resp;
    assign lsu_r_data_o    = lsu_rd.r_data;

    assign lsu_wr.aw_valid = lsu_aw_valid_i;
    assign lsu_wr.aw_addr  = lsu_aw_addr_i;
    assign lsu_wr.w_valid  = lsu_w_valid_i;
    assign lsu_wr.w_data   = lsu_w_data_i;
    assign lsu_wr.w_strb   = lsu_w_strb_i;
    assign lsu_wr.b_ready  = lsu_b_ready_i;
    assign lsu_aw_ready_o  = lsu_wr.aw_ready;
    assign lsu_w_ready_o   = lsu_wr.w_ready;
    assign lsu_b_valid_o   = lsu_wr.b_valid;
    assign lsu_b_resp_o    = lsu_wr.b_resp;

    axi_arbiter u_arbiter (
        .clk    (clk),
        .rst    (rst),
        .ifu_rd (ifu_rd),
        .lsu_rd (lsu_rd),
        .lsu_wr (lsu_wr),
        .mem_rd (mem_rd),
        .mem_wr (mem_wr)
    );

    axi_sram u_sram (
        .clk (clk),
        .rst (rst),
        .rd  (mem_rd),
        .wr  (mem_wr)
    );

endmodule

//--- tb_mem_subsys.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module tb_mem_subsys
    import axi_pkg::*;
();

    localparam int N_DIRECTED = 16;
    localparam int N_RANDOM   = 200;
    localparam int TXN_TOTAL  = `MEM_DEPTH + N_DIRECTED + 2 * N_RANDOM;
    localparam int WATCHDOG   = 5 + 40 * TXN_TOTAL;

    logic      clk;
    logic      rst;
    logic      ifu_ar_valid_i;
    addr_t     ifu_ar_addr_i;
    logic      ifu_ar_ready_o;
    logic      ifu_r_ready_i;
    logic      ifu_r_valid_o;
    axi_resp_e ifu_r_resp_o;
    data_t     ifu_r_data_o;
    logic      lsu_ar_valid_i;
    addr_t     lsu_ar_addr_i;
    logic      lsu_ar_ready_o;
    logic      lsu_r_ready_i;
    logic      lsu_r_valid_o;
    axi_resp_e lsu_r_resp_o;
    data_t     lsu_r_data_o;
    logic      lsu_aw_valid_i;
    addr_t     lsu_aw_addr_i;
    logic      lsu_aw_ready_o;
    logic      lsu_w_valid_i;
    data_t     lsu_w_data_i;
    strb_t     lsu_w_strb_i;
    logic      lsu_w_ready_o;
    logic      lsu_b_ready_i;
    logic      lsu_b_valid_o;
    axi_resp_e lsu_b_resp_o;

    data_t     shadow [`MEM_DEPTH];
    int        cycle_cnt = 0;
    int        fail_count = 0;

    // Index 0 is the IFU, index 1 the LSU
    data_t     exp_data_q [2][$];
    axi_resp_e exp_resp_q [2][$];
    string     exp_name_q [2][$];
    axi_resp_e exp_bresp_q [$];
    string     exp_bname_q [$];
    data_t     got_data [2];
    axi_resp_e got_resp [2];
    int        got_lat [2];
    int        got_cyc [2];

    mem_subsys_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic data_t fill_word(input addr_t addr);
        return {addr ^ 32'h5a5a_c3c3, ~addr};
    endfunction

    function automatic addr_t rand_addr();
        // A few words past the end land out of range
        return addr_t'(($urandom % (`MEM_DEPTH + 16)) * `MEM_STRB_W);
    endfunction

    // Expected read result from the shadow copy
    function automatic void ref_read(
        input  addr_t     addr,
        output data_t     data,
        output axi_resp_e resp
    );
        longint unsigned idx;
        idx = addr / `MEM_STRB_W;
        if (idx < `MEM_DEPTH) begin
            data = shadow[idx];
            resp = OKAY;
        end else begin
            data = '0;
            resp = SLVERR;
        end
    endfunction

    function automatic void shadow_write(input addr_t addr, input data_t data, input strb_t strb);
        longint unsigned idx;
        idx = addr / `MEM_STRB_W;
        if (idx < `MEM_DEPTH) begin
            for (int i = 0; i < `MEM_STRB_W; i++) begin
                if (strb[i]) begin
                    shadow[idx][8*i +: 8] = data[8*i +: 8];
                end
            end
        end
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Checks failed");
        fail_count++;
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            stop_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
        if (act !== exp) begin
            stop_run($sformatf("Mismatch %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_run($sformatf("Mismatch %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic compare_read(input int m, input data_t data, input axi_resp_e resp);
        string name;
        if (exp_data_q[m].size() == 0) begin
            stop_run("Read data arrived without a pending read");
        end
        name = exp_name_q[m].pop_front();
        check_data(name, exp_data_q[m].pop_front(), data);
        check_resp(name, exp_resp_q[m].pop_front(), resp);
    endtask

    // Inputs are stable at the falling edge, handshakes complete at the next rising one
    always @(negedge clk) begin
        if (!rst) begin
            if (ifu_r_valid_o && ifu_r_ready_i) begin
                compare_read(0, ifu_r_data_o, ifu_r_resp_o);
            end
            if (lsu_r_valid_o && lsu_r_ready_i) begin
                compare_read(1, lsu_r_data_o, lsu_r_resp_o);
            end
            if (lsu_b_valid_o && lsu_b_ready_i) begin
                if (exp_bresp_q.size() == 0) begin
                    stop_run("Write response arrived without a pending write");
                end
                check_resp(exp_bname_q.pop_front(), exp_bresp_q.pop_front(), lsu_b_resp_o);
            end
        end
    end

    task automatic set_ar(input bit lsu, input logic valid, input addr_t addr);
        if (lsu) begin
            lsu_ar_valid_i = valid;
            lsu_ar_addr_i  = addr;
        end else begin
            ifu_ar_valid_i = valid;
            ifu_ar_addr_i  = addr;
        end
    endtask

    task automatic set_r_ready(input bit lsu, input logic ready);
        if (lsu) begin
            lsu_r_ready_i = ready;
        end else begin
            ifu_r_ready_i = ready;
        end
    endtask

    // Latency counts falling edges from ar_valid to the R handshake
    task automatic do_read(input bit lsu, input addr_t addr, input string name, input bit stall);
        data_t     exp_d;
        axi_resp_e exp_r;
        ref_read(addr, exp_d, exp_r);
        exp_data_q[lsu].push_back(exp_d);
        exp_resp_q[lsu].push_back(exp_r);
        exp_name_q[lsu].push_back(name);
        set_ar(lsu, 1'b1, addr);
        set_r_ready(lsu, stall ? 1'($urandom % 2) : 1'b1);
        got_lat[lsu] = -1;
        do begin
            @(negedge clk);
            got_lat[lsu]++;
        end while (!(lsu ? lsu_ar_ready_o : ifu_ar_ready_o));
        @(posedge clk);
        #1;
        set_ar(lsu, 1'b0, '0);
        forever begin
            @(negedge clk);
            got_lat[lsu]++;
            if (lsu ? (lsu_r_valid_o && lsu_r_ready_i) : (ifu_r_valid_o && ifu_r_ready_i)) begin
                break;
            end
            @(posedge clk);
            #1;
            set_r_ready(lsu, stall ? 1'($urandom % 2) : 1'b1);
        end
        got_data[lsu] = lsu ? lsu_r_data_o : ifu_r_data_o;
        got_resp[lsu] = lsu ? lsu_r_resp_o : ifu_r_resp_o;
        got_cyc[lsu]  = cycle_cnt;
        @(posedge clk);
        #1;
        set_r_ready(lsu, 1'b0);
    endtask

    task automatic do_write(
        input  addr_t     addr,
        input  data_t     data,
        input  strb_t     strb,
        input  string     name,
        input  bit        stall,
        output axi_resp_e resp
    );
        data_t     old_d;
        axi_resp_e exp_r;
        ref_read(addr, old_d, exp_r);
        exp_bresp_q.push_back(exp_r);
        exp_bname_q.push_back(name);
        lsu_aw_valid_i = 1'b1;
        lsu_aw_addr_i  = addr;
        lsu_w_valid_i  = 1'b1;
        lsu_w_data_i   = data;
        lsu_w_strb_i   = strb;
        lsu_b_ready_i  = stall ? 1'($urandom % 2) : 1'b1;
        do begin
            @(negedge clk);
        end while (!(lsu_aw_ready_o && lsu_w_ready_o));
        @(posedge clk);
        shadow_write(addr, data, strb);
        #1;
        lsu_aw_valid_i = 1'b0;
        lsu_w_valid_i  = 1'b0;
        forever begin
            @(negedge clk);
            if (lsu_b_valid_o && lsu_b_ready_i) begin
                break;
            end
            @(posedge clk);
            #1;
            lsu_b_ready_i = stall ? 1'($urandom % 2) : 1'b1;
        end
        resp = lsu_b_resp_o;
        @(posedge clk);
        #1;
        lsu_b_ready_i = 1'b0;
    endtask

    initial begin
        int unsigned seed_ret;
        int          op;
        addr_t       addr;
        addr_t       addr2;
        axi_resp_e   wresp;
        seed_ret = $urandom(50725);
        rst = 1'b1;
        set_ar(1'b0, 1'b0, '0);
        set_ar(1'b1, 1'b0, '0);
        set_r_ready(1'b0, 1'b0);
        set_r_ready(1'b1, 1'b0);
        lsu_aw_valid_i = 1'b0;
        lsu_aw_addr_i  = '0;
        lsu_w_valid_i  = 1'b0;
        lsu_w_data_i   = '0;
        lsu_w_strb_i   = '0;
        lsu_b_ready_i  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Every word gets known contents before any read
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            addr = addr_t'(i * `MEM_STRB_W);
            do_write(addr, fill_word(addr), '1, "preload", 1'b0, wresp);
        end

        do_write(32'h40, 64'h0123_4567_89ab_cdef, '1, "lsu_write", 1'b0, wresp);
        check_resp("lsu_write", OKAY, wresp);
        do_read(1'b1, 32'h40, "lsu_readback", 1'b0);
        check_data("lsu_readback", 64'h0123_4567_89ab_cdef, got_data[1]);
        check_resp("lsu_readback", OKAY, got_resp[1]);

        // Bytes 0, 1, 4 and 6 enabled
        do_write(32'h40, 64'hffee_ddcc_bbaa_9988, 8'b0101_0011, "partial_write", 1'b0, wresp);
        do_read(1'b1, 32'h40, "partial_readback", 1'b0);
        check_data("partial_readback", 64'h01ee_45cc_89ab_9988, got_data[1]);

        do_read(1'b0, 32'h40, "ifu_read_lsu_word", 1'b0);
        check_data("ifu_read_lsu_word", 64'h01ee_45cc_89ab_9988, got_data[0]);
        do_read(1'b0, 32'h100, "ifu_read_preload", 1'b0);
        check_data("ifu_read_preload", fill_word(32'h100), got_data[0]);

        fork
            do_read(1'b1, 32'h08, "tie_lsu", 1'b0);
            do_read(1'b0, 32'h10, "tie_ifu", 1'b0);
        join
        if (got_cyc[1] >= got_cyc[0]) begin
            stop_run("LSU read data did not arrive before IFU read data on a tie");
        end

        do_read(1'b1, 32'h800, "oor_read", 1'b0);
        check_data("oor_read", '0, got_data[1]);
        check_resp("oor_read", SLVERR, got_resp[1]);
        do_read(1'b0, 32'hffff_fff8, "oor_read_high", 1'b0);
        check_resp("oor_read_high", SLVERR, got_resp[0]);
        do_write(32'h800, '1, '1, "oor_write", 1'b0, wresp);
        check_resp("oor_write", SLVERR, wresp);
        do_read(1'b0, 32'h0, "oor_alias", 1'b0);
        check_data("oor_alias", fill_word(32'h0), got_data[0]);

        for (int n = 0; n < N_RANDOM; n++) begin
            op    = $urandom % 3;
            addr  = rand_addr();
            addr2 = rand_addr();
            if (op == 0) begin
                do_write(addr, {$urandom, $urandom}, strb_t'($urandom), "rand_write", 1'b1, wresp);
            end else if (op == 1) begin
                do_read(1'($urandom % 2), addr, "rand_read", 1'b1);
            end else begin
                fork
                    do_read(1'b1, addr, "rand_lsu", 1'b1);
                    do_read(1'b0, addr2, "rand_ifu", 1'b1);
                join
            end
        end

        do_read(1'b1, 32'h18, "latency", 1'b0);
        check_latency("latency", 2, got_lat[1]);

        repeat (4) @(posedge clk);
        if (exp_bresp_q.size() != 0 || exp_data_q[0].size() != 0 || exp_data_q[1].size() != 0) begin
            stop_run("Responses still pending at the end of the run");
        end
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- build.f
+incdir+.
axi_pkg.sv
arb_pkg.sv
axi_rd_if.sv
axi_wr_if.sv
axi_arbiter.sv
axi_sram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_mem_subsys \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_mem_subsys > sim.log 2>&1 || true
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0
